// ==== core_vectors.txt ====
// 0x00: program length in words, record count; 0x10: program words
// 0x80: records of three words each: test number, rd, expected value
@00
00000015 00000012
@10
00500093  // addi  x1, x0, 5
ffd00113  // addi  x2, x0, -3
002081b3  // add   x3, x1, x2
40208233  // sub   x4, x1, x2
001092b3  // sll   x5, x1, x1
00112333  // slt   x6, x2, x1
001133b3  // sltu  x7, x2, x1
0020c433  // xor   x8, x1, x2
001154b3  // srl   x9, x2, x1
40115533  // sra   x10, x2, x1
0020e5b3  // or    x11, x1, x2
0020f633  // and   x12, x1, x2
123456b7  // lui   x13, 0x12345
fff68693  // addi  x13, x13, -1
00708013  // addi  x0, x1, 7
00000000  // all-zero word
00102023  // sw    x1, 0(x0)
fffff717  // auipc x14, 0xfffff at pc 0x44
40475793  // srai  x15, x14, 4
fff0b813  // sltiu x16, x1, -1
40d788b3  // sub   x17, x15, x13
@80
3 01 00000005
3 02 fffffffd
2 03 00000002
2 04 00000008
2 05 000000a0
2 06 00000001
2 07 00000000
2 08 fffffff8
2 09 07ffffff
2 0a ffffffff
2 0b fffffffd
2 0c 00000005
3 0d 12345000
4 0d 12344fff
3 0e fffff044
3 0f ffffff04
3 10 00000001
4 11 edcbaf05

// ==== sources.f ====
core_pkg.sv
reg_file.sv
decode_1.sv
decode_2.sv
exec.sv
core.sv
tb_core.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and pass only if the log holds the pass message
rm -rf obj_dir sim.log
verilator --binary --assert --timescale 1ns/1ps --top-module tb_core \
    -f sources.f -o tb_core &&
    ./obj_dir/tb_core > sim.log 2>&1 ||
    echo "build or simulation aborted"
cat sim.log 2>/dev/null
grep -qx "No errors" sim.log && echo "simulation passed" && exit 0
echo "simulation failed"
exit 1

// ==== tb_core.sv ====
`default_nettype none

module tb_core import core_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int         RESET_CYCLES = 16;
    localparam int         REC_TIMEOUT  = 200;
    localparam int         TAIL_CYCLES  = 50;
    localparam logic [7:0] PROG_BASE    = 8'h10;
    localparam logic [7:0] REC_BASE     = 8'h80;
    localparam word_t      LCG_SEED     = 32'h8def_f437;

    logic     CLK;
    logic     RST;
    logic     inst_rvalid = 1'b0;
    word_t    inst_rdata  = '0;
    logic     mem_wait    = 1'b0;
    logic     inst_rden;
    word_t    inst_raddr;
    logic     wb_valid;
    reg_idx_t wb_rd;
    word_t    wb_data;

    // header, program words and expected records
    word_t vec [0:255];
    word_t prog_len;
    word_t rec_count;

    word_t lcg_state = LCG_SEED;
    int    test_err [0:7];
    int    reset_err    = 0;
    int    hold_err     = 0;
    int    stall_cycles = 0;
    logic  hold_pending;
    word_t held_raddr;

    core core_i (
        .CLK         (CLK),
        .RST         (RST),
        .inst_rvalid (inst_rvalid),
        .inst_rdata  (inst_rdata),
        .mem_wait    (mem_wait),
        .inst_rden   (inst_rden),
        .inst_raddr  (inst_raddr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    function automatic word_t lcg_next(input word_t state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // words past the end of the program read as zero
    function automatic word_t fetch_word(input word_t addr);
        if ((addr >> 2) < prog_len) begin
            return vec[PROG_BASE + addr[9:2]];
        end
        return '0;
    endfunction

    task automatic check_wb_rd(input reg_idx_t exp, input reg_idx_t act, inout int err);
        if (act !== exp) begin
            $display("FAIL %0t wb_rd expected %0d actual %0d", $time, exp, act);
            err++;
        end
    endtask

    task automatic check_wb_data(input word_t exp, input word_t act, inout int err);
        if (act !== exp) begin
            $display("FAIL %0t wb_data expected %h actual %h", $time, exp, act);
            err++;
        end
    endtask

    task automatic check_fetch_addr(input word_t exp, input word_t act, inout int err);
        if (act !== exp) begin
            $display("FAIL %0t inst_raddr expected %h actual %h", $time, exp, act);
            err++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int err);
        if (err == 0) begin
            $display("test %0d %s: passed", num, name);
        end else begin
            $display("test %0d %s: failed with %0d mismatches", num, name, err);
        end
    endtask

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // memory model answers an accepted request one cycle later
    always @(posedge CLK) begin
        if (RST) begin
            mem_wait    <= 1'b0;
            inst_rvalid <= 1'b0;
        end else begin
            lcg_state = lcg_next(lcg_state);
            // high about one cycle in four
            mem_wait    <= (lcg_state[31:30] == 2'b00);
            inst_rvalid <= inst_rden && !mem_wait;
            if (inst_rden && !mem_wait) begin
                inst_rdata <= fetch_word(inst_raddr);
            end
        end
    end

    // reset levels and address hold while stalled
    always @(negedge CLK) begin
        if (RST) begin
            if (inst_rden !== 1'b0 || wb_valid !== 1'b0) begin
                $display("inst_rden or wb_valid not low during reset at %0t", $time);
                reset_err++;
            end
            hold_pending = 1'b0;
        end else begin
            if (hold_pending) begin
                check_fetch_addr(held_raddr, inst_raddr, hold_err);
            end
            hold_pending = (inst_rden === 1'b1) && (mem_wait === 1'b1);
            held_raddr   = inst_raddr;
            if (hold_pending) begin
                stall_cycles++;
            end
        end
    end

    initial begin
        int         waited;
        int         extra;
        int         total;
        int         failed_tests;
        logic       timed_out;
        logic [2:0] grp;
        logic [7:0] pos;
        reg_idx_t   exp_rd;
        word_t      exp_data;

        RST <= 1'b1;
        test_err = '{default: 0};
        timed_out = 1'b0;
        extra = 0;
        $readmemh("core_vectors.txt", vec);
        prog_len  = vec[0];
        rec_count = vec[1];
        if ($isunknown(prog_len) || $isunknown(rec_count) || rec_count == '0) begin
            $display("core_vectors.txt could not be read or holds no records");
            test_err[0]++;
            timed_out = 1'b1;
        end

        repeat (RESET_CYCLES) @(posedge CLK);
        RST <= 1'b0;

        // first accepted request
        waited = 0;
        do begin
            @(negedge CLK);
            waited++;
        end while (!(inst_rden === 1'b1 && mem_wait === 1'b0) && waited < REC_TIMEOUT);
        if (inst_rden === 1'b1 && mem_wait === 1'b0) begin
            check_fetch_addr('0, inst_raddr, test_err[1]);
        end else begin
            $display("no fetch request accepted within %0d cycles after reset", REC_TIMEOUT);
            test_err[1]++;
            timed_out = 1'b1;
        end
        test_err[1] += reset_err;
        report_test(1, "reset and first fetch", test_err[1]);

        for (int i = 0; i < int'(rec_count) && !timed_out; i++) begin
            pos      = REC_BASE + 8'(3 * i);
            grp      = vec[pos][2:0];
            exp_rd   = vec[pos + 8'd1][4:0];
            exp_data = vec[pos + 8'd2];
            waited = 0;
            do begin
                @(negedge CLK);
                waited++;
            end while (wb_valid !== 1'b1 && waited < REC_TIMEOUT);
            if (wb_valid !== 1'b1) begin
                $display("writeback record %0d (x%0d = %h) did not arrive in %0d cycles",
                         i, exp_rd, exp_data, REC_TIMEOUT);
                test_err[grp]++;
                test_err[5]++;
                timed_out = 1'b1;
            end else begin
                check_wb_rd(exp_rd, wb_rd, test_err[grp]);
                check_wb_data(exp_data, wb_data, test_err[grp]);
            end
        end
        report_test(2, "register-register operations", test_err[2]);
        report_test(3, "immediate operations, lui and auipc", test_err[3]);
        report_test(4, "dependent instructions", test_err[4]);

        // nothing may retire after the last expected record
        if (!timed_out) begin
            repeat (TAIL_CYCLES) begin
                @(negedge CLK);
                if (wb_valid === 1'b1) begin
                    $display("extra writeback x%0d = %h after the last record", wb_rd, wb_data);
                    extra++;
                end
            end
        end
        test_err[5] += extra;
        report_test(5, "x0 writes and bubbles", test_err[5]);

        if (stall_cycles == 0) begin
            $display("mem_wait never stalled a fetch request");
            test_err[6]++;
        end
        test_err[6] += hold_err;
        report_test(6, "fetch stalls", test_err[6]);

        total = test_err.sum();
        failed_tests = 0;
        for (int t = 1; t <= 6; t++) begin
            if (test_err[3'(t)] != 0) begin
                failed_tests++;
            end
        end
        $display("tests passed %0d, tests failed %0d, mismatches %0d, stall cycles %0d",
                 6 - failed_tests, failed_tests, total, stall_cycles);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== core.sv ====
`default_nettype none

module core import core_pkg::*; (
    input  wire        CLK,
    input  wire        RST,
    input  wire        inst_rvalid,
    input  wire word_t inst_rdata,
    input  wire        mem_wait,
    output logic       inst_rden,
    output word_t      inst_raddr,
    output logic       wb_valid,
    output reg_idx_t   wb_rd,
    output word_t      wb_data
);

    // pc of the request the memory is answering
    word_t      req_pc;

    logic       d1_valid;
    word_t      d1_pc;
    logic [6:0] d1_opcode;
    reg_idx_t   d1_rd;
    reg_idx_t   d1_rs1;
    reg_idx_t   d1_rs2;
    logic [2:0] d1_funct3;
    logic [6:0] d1_funct7;
    word_t      d1_imm_i;
    word_t      d1_imm_u;

    reg_idx_t   rf_raddr1;
    reg_idx_t   rf_raddr2;
    word_t      rf_rdata1;
    word_t      rf_rdata2;
    logic       rf_we;
    reg_idx_t   rf_waddr;
    word_t      rf_wdata;

    logic       d2_valid;
    reg_idx_t   d2_rd;
    alu_op_t    d2_alu_op;
    word_t      d2_opa;
    word_t      d2_opb;

    logic       ex_fwd_valid;
    reg_idx_t   ex_fwd_rd;
    word_t      ex_fwd_data;

    // fetch issues a new request every cycle without wait
    always_ff @(posedge CLK) begin
        if (RST) begin
            inst_rden  <= 1'b0;
            inst_raddr <= RESET_PC;
        end else if (!mem_wait) begin
            inst_rden  <= 1'b1;
            inst_raddr <= inst_raddr + 32'd4;
        end
    end

    // remember the accepted address for the word coming back
    always_ff @(posedge CLK) begin
        if (inst_rden && !mem_wait) begin
            req_pc <= inst_raddr;
        end
    end

    decode_1 decode_1_i (
        .CLK        (CLK),
        .RST        (RST),
        .inst_valid (inst_rvalid),
        .inst_pc    (req_pc),
        .inst_data  (inst_rdata),
        .d1_valid   (d1_valid),
        .d1_pc      (d1_pc),
        .d1_opcode  (d1_opcode),
        .d1_rd      (d1_rd),
        .d1_rs1     (d1_rs1),
        .d1_rs2     (d1_rs2),
        .d1_funct3  (d1_funct3),
        .d1_funct7  (d1_funct7),
        .d1_imm_i   (d1_imm_i),
        .d1_imm_u   (d1_imm_u)
    );

    decode_2 decode_2_i (
        .CLK          (CLK),
        .RST          (RST),
        .d1_valid     (d1_valid),
        .d1_pc        (d1_pc),
        .d1_opcode    (d1_opcode),
        .d1_rd        (d1_rd),
        .d1_rs1       (d1_rs1),
        .d1_rs2       (d1_rs2),
        .d1_funct3    (d1_funct3),
        .d1_funct7    (d1_funct7),
        .d1_imm_i     (d1_imm_i),
        .d1_imm_u     (d1_imm_u),
        .rf_rdata1    (rf_rdata1),
        .rf_rdata2    (rf_rdata2),
        .ex_fwd_valid (ex_fwd_valid),
        .ex_fwd_rd    (ex_fwd_rd),
        .ex_fwd_data  (ex_fwd_data),
        .rf_raddr1    (rf_raddr1),
        .rf_raddr2    (rf_raddr2),
        .d2_valid     (d2_valid),
        .d2_rd        (d2_rd),
        .d2_alu_op    (d2_alu_op),
        .d2_opa       (d2_opa),
        .d2_opb       (d2_opb)
    );

    exec exec_i (
        .CLK          (CLK),
        .RST          (RST),
        .d2_valid     (d2_valid),
        .d2_rd        (d2_rd),
        .d2_alu_op    (d2_alu_op),
        .d2_opa       (d2_opa),
        .d2_opb       (d2_opb),
        .ex_fwd_valid (ex_fwd_valid),
        .ex_fwd_rd    (ex_fwd_rd),
        .ex_fwd_data  (ex_fwd_data),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data)
    );

    reg_file reg_file_i (
        .CLK    (CLK),
        .RST    (RST),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    // a stalled request keeps its address until it is accepted
    a_raddr_hold: assert property (
        @(posedge CLK) disable iff (RST)
        (inst_rden && mem_wait) |=> $stable(inst_raddr)
    ) else $error("inst_raddr changed during mem_wait");

endmodule

`default_nettype wire

// ==== exec.sv ====
`default_nettype none

module exec import core_pkg::*; (
    input  wire           CLK,
    input  wire           RST,
    input  wire           d2_valid,
    input  wire reg_idx_t d2_rd,
    input  wire alu_op_t  d2_alu_op,
    input  wire word_t    d2_opa,
    input  wire word_t    d2_opb,
    output logic          ex_fwd_valid,
    output reg_idx_t      ex_fwd_rd,
    output word_t         ex_fwd_data,
    output logic          rf_we,
    output reg_idx_t      rf_waddr,
    output word_t         rf_wdata,
    output logic          wb_valid,
    output reg_idx_t      wb_rd,
    output word_t         wb_data
);

    word_t      alu_result;
    logic [4:0] shamt;

    // only the low five bits count for shifts
    assign shamt = d2_opb[4:0];

    always_comb begin
        case (d2_alu_op)
            ALU_ADD: begin
                alu_result = d2_opa + d2_opb;
            end
            ALU_SUB: begin
                alu_result = d2_opa - d2_opb;
            end
            ALU_SLL: begin
                alu_result = d2_opa << shamt;
            end
            ALU_SLT: begin
                alu_result = {{(XLEN-1){1'b0}}, ($signed(d2_opa) < $signed(d2_opb))};
            end
            ALU_SLTU: begin
                alu_result = {{(XLEN-1){1'b0}}, (d2_opa < d2_opb)};
            end
            ALU_XOR: begin
                alu_result = d2_opa ^ d2_opb;
            end
            ALU_SRL: begin
                alu_result = d2_opa >> shamt;
            end
            ALU_SRA: begin
                alu_result = word_t'($signed(d2_opa) >>> shamt);
            end
            ALU_OR: begin
                alu_result = d2_opa | d2_opb;
            end
            ALU_AND: begin
                alu_result = d2_opa & d2_opb;
            end
            ALU_PASS_B: begin
                alu_result = d2_opb;
            end
            default: begin
                alu_result = '0;
            end
        endcase
    end

    // bypass path to decode_2 in the same cycle as the result
    assign ex_fwd_valid = d2_valid;
    assign ex_fwd_rd    = d2_rd;
    assign ex_fwd_data  = alu_result;

    // register file takes the write on the edge that loads wb_*
    assign rf_we    = d2_valid;
    assign rf_waddr = d2_rd;
    assign rf_wdata = alu_result;

    always_ff @(posedge CLK) begin
        if (RST) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= d2_valid;
        end
    end

    always_ff @(posedge CLK) begin
        wb_rd   <= d2_rd;
        wb_data <= alu_result;
    end

    // decode_2 filters x0 writes before they get here
    a_wb_rd_nonzero: assert property (
        @(posedge CLK) disable iff (RST)
        wb_valid |-> (wb_rd != '0)
    ) else $error("writeback reported for x0");

endmodule

`default_nettype wire

// ==== decode_2.sv ====
`default_nettype none

module decode_2 import core_pkg::*; (
    input  wire           CLK,
    input  wire           RST,
    input  wire           d1_valid,
    input  wire word_t    d1_pc,
    input  wire [6:0]     d1_opcode,
    input  wire reg_idx_t d1_rd,
    input  wire reg_idx_t d1_rs1,
    input  wire reg_idx_t d1_rs2,
    input  wire [2:0]     d1_funct3,
    input  wire [6:0]     d1_funct7,
    input  wire word_t    d1_imm_i,
    input  wire word_t    d1_imm_u,
    input  wire word_t    rf_rdata1,
    input  wire word_t    rf_rdata2,
    input  wire           ex_fwd_valid,
    input  wire reg_idx_t ex_fwd_rd,
    input  wire word_t    ex_fwd_data,
    output reg_idx_t      rf_raddr1,
    output reg_idx_t      rf_raddr2,
    output logic          d2_valid,
    output reg_idx_t      d2_rd,
    output alu_op_t       d2_alu_op,
    output word_t         d2_opa,
    output word_t         d2_opb
);

    word_t   src1;
    word_t   src2;
    word_t   opa_next;
    word_t   opb_next;
    alu_op_t alu_op_next;
    logic    supported;

    // funct3 decode shared by OP and OP-IMM where SUB only exists for OP
    function automatic alu_op_t funct_to_alu(input logic [2:0] funct3, input logic alt,
                                             input logic reg_op);
        alu_op_t op;
        case (funct3)
            3'b000:  op = (alt && reg_op) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign rf_raddr1 = d1_rs1;
    assign rf_raddr2 = d1_rs2;

    // exec result wins over the stale register file value
    assign src1 = (ex_fwd_valid && ex_fwd_rd == d1_rs1) ? ex_fwd_data : rf_rdata1;
    assign src2 = (ex_fwd_valid && ex_fwd_rd == d1_rs2) ? ex_fwd_data : rf_rdata2;

    always_comb begin
        supported   = 1'b1;
        opa_next    = src1;
        opb_next    = src2;
        alu_op_next = ALU_ADD;
        case (d1_opcode)
            OPC_OP: begin
                alu_op_next = funct_to_alu(d1_funct3, d1_funct7[5], 1'b1);
            end
            OPC_OP_IMM: begin
                opb_next    = d1_imm_i;
                alu_op_next = funct_to_alu(d1_funct3, d1_funct7[5], 1'b0);
            end
            OPC_LUI: begin
                opa_next    = '0;
                opb_next    = d1_imm_u;
                alu_op_next = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                opa_next = d1_pc;
                opb_next = d1_imm_u;
            end
            default: begin
                supported = 1'b0;
            end
        endcase
    end

    // x0 destinations and unknown opcodes become bubbles here
    always_ff @(posedge CLK) begin
        if (RST) begin
            d2_valid <= 1'b0;
        end else begin
            d2_valid <= d1_valid && supported && (d1_rd != '0);
        end
    end

    always_ff @(posedge CLK) begin
        d2_rd     <= d1_rd;
        d2_alu_op <= alu_op_next;
        d2_opa    <= opa_next;
        d2_opb    <= opb_next;
    end

endmodule

`default_nettype wire

// ==== decode_1.sv ====
`default_nettype none

module decode_1 import core_pkg::*; (
    input  wire        CLK,
    input  wire        RST,
    input  wire        inst_valid,
    input  wire word_t inst_pc,
    input  wire word_t inst_data,
    output logic       d1_valid,
    output word_t      d1_pc,
    output logic [6:0] d1_opcode,
    output reg_idx_t   d1_rd,
    output reg_idx_t   d1_rs1,
    output reg_idx_t   d1_rs2,
    output logic [2:0] d1_funct3,
    output logic [6:0] d1_funct7,
    output word_t      d1_imm_i,
    output word_t      d1_imm_u
);

    // fetched word held for one cycle
    word_t inst_q;

    always_ff @(posedge CLK) begin
        if (RST) begin
            d1_valid <= 1'b0;
        end else begin
            d1_valid <= inst_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (inst_valid) begin
            inst_q <= inst_data;
            d1_pc  <= inst_pc;
        end
    end

    // fixed field positions of the base encoding
    assign d1_opcode = inst_q[6:0];
    assign d1_rd     = inst_q[11:7];
    assign d1_funct3 = inst_q[14:12];
    assign d1_rs1    = inst_q[19:15];
    assign d1_rs2    = inst_q[24:20];
    assign d1_funct7 = inst_q[31:25];

    // I form sign extended from bit 31
    assign d1_imm_i = {{20{inst_q[31]}}, inst_q[31:20]};

    // U form holds the upper 20 bits over a zero low part
    assign d1_imm_u = {inst_q[31:12], 12'b0};

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`default_nettype none

module reg_file import core_pkg::*; (
    input  wire           CLK,
    input  wire           RST,
    input  wire reg_idx_t raddr1,
    input  wire reg_idx_t raddr2,
    input  wire           we,
    input  wire reg_idx_t waddr,
    input  wire word_t    wdata,
    output word_t         rdata1,
    output word_t         rdata2
);

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    a_no_x0_write: assert property (
        @(posedge CLK) disable iff (RST)
        we |-> (waddr != '0)
    ) else $error("register file write to x0");

endmodule

`default_nettype wire

// ==== core_pkg.sv ====
`default_nettype none

package core_pkg;

    // data and address width
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // one word below zero, so the first fetch request goes to address 0
    localparam word_t RESET_PC = 32'hffff_fffc;

    // major opcodes handled by this core
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // alu operations where PASS_B forwards operand b unchanged
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_t;

endpackage

`default_nettype wire
